// ==== exPipe_consts.svh ====
// Widths, micro-command codes, sub-op codes, hold counts and null register id
`ifndef EXPIPE_CONSTS_SVH
`define EXPIPE_CONSTS_SVH

`define EX_REGID_W		6			// Register id width
`define EX_VAL_W		64			// Datapath width
`define EX_MUL_W		32			// Multiplier operand width
`define EX_HOLD_W		4			// Hold counter width
`define EX_REG_ZZR		6'h00		// Null destination, write dropped

// Micro-commands
`define EX_UCMD_NOP		6'h00
`define EX_UCMD_ALU3	6'h01		// Three-register ALU op
`define EX_UCMD_ALUCMP	6'h02		// Compare into status T bit
`define EX_UCMD_MUL3	6'h03		// Multiply, multi-cycle
`define EX_UCMD_IXT		6'h04		// System ops, sys view of sub-op

// ALU sub-ops
`define EX_ALU_ADD		4'h0
`define EX_ALU_SUB		4'h1
`define EX_ALU_AND		4'h2
`define EX_ALU_OR		4'h3
`define EX_ALU_XOR		4'h4
`define EX_CMP_EQ		4'h5
`define EX_CMP_GT		4'h6		// Unsigned greater

// System sub-ops
`define EX_IXT_NOP		4'h0
`define EX_IXT_SLEEP	4'h1

`define EX_HOLD_SLEEP	4'd8		// Sleep stall length
`define EX_HOLD_MUL		4'd1		// Wait for multiplier stage two

`endif

// ==== exPipePkg.sv ====
// Package with op, sub-op union, ALU result, multiplier operand and writeback types
`include "exPipe_consts.svh"

package exPipePkg;

	// Sub-op as seen by the ALU
	typedef struct packed {
		logic [1:0]		spare;		// Unused, keeps width
		logic [3:0]		aluOp;		// EX_ALU_* / EX_CMP_*
	} exAluSub_t;

	// Sub-op as seen by system commands
	typedef struct packed {
		logic [1:0]		spare;
		logic [3:0]		sysOp;		// EX_IXT_*
	} exSysSub_t;

	// One decoded field, two readings depending on ucmd
	typedef union packed {
		exAluSub_t		alu;
		exSysSub_t		sys;
	} exSubOp_u;

	// Issued micro-operation
	typedef struct packed {
		logic [5:0]					ucmd;		// EX_UCMD_*
		exSubOp_u					subOp;
		logic [`EX_REGID_W-1:0]		regIdRm;	// Destination
	} exOp_t;

	// ALU output into execute-2
	typedef struct packed {
		logic [`EX_VAL_W-1:0]	value;
		logic					carry;		// Add carry / sub borrow
		logic					tBit;		// Compare result
	} exAluRes_t;

	// Multiplier stage one operands
	typedef struct packed {
		logic [`EX_MUL_W-1:0]	opA;		// Low half of Rs
		logic [`EX_MUL_W-1:0]	opB;		// Low half of Rt
	} exMulOps_t;

	// Register writeback
	typedef struct packed {
		logic [`EX_REGID_W-1:0]		regId;		// ZZR when nothing written
		logic [`EX_VAL_W-1:0]		value;
	} exWb_t;

endpackage

// ==== exAlu.sv ====
// Execute-1 ALU with registered op and result, carry and compare flags
`timescale 1ns/1ps
`include "exPipe_consts.svh"

module exAlu import exPipePkg::*; (
	input  logic					clock,
	input  logic					rst,
	input  logic					issue,		// Op valid from decode
	input  logic					exHold,		// Stall from execute-2
	input  exOp_t					opIn,
	input  logic [`EX_VAL_W-1:0]	regValRs,
	input  logic [`EX_VAL_W-1:0]	regValRt,
	output exOp_t					ex1Op,
	output exAluRes_t				aluRes
);

	logic			accept;		// Op taken this edge
	exAluRes_t		aluNext;	// Result before the register

	assign accept = issue && !exHold;

	always_comb begin
		logic [`EX_VAL_W:0]		wide;	// One extra bit for carry out

		wide			= '0;
		aluNext.value	= '0;
		aluNext.carry	= 1'b0;
		aluNext.tBit	= 1'b0;

		case (opIn.subOp.alu.aluOp)
			`EX_ALU_ADD: begin
				wide			= {1'b0, regValRs} + {1'b0, regValRt};
				aluNext.value	= wide[`EX_VAL_W-1:0];
				aluNext.carry	= wide[`EX_VAL_W];		// Carry out
			end
			`EX_ALU_SUB: begin
				wide			= {1'b0, regValRs} - {1'b0, regValRt};
				aluNext.value	= wide[`EX_VAL_W-1:0];
				aluNext.carry	= wide[`EX_VAL_W];		// Borrow, Rs < Rt
			end
			`EX_ALU_AND: aluNext.value = regValRs & regValRt;
			`EX_ALU_OR:  aluNext.value = regValRs | regValRt;
			`EX_ALU_XOR: aluNext.value = regValRs ^ regValRt;
			`EX_CMP_EQ: begin
				aluNext.tBit	= (regValRs == regValRt);
			end
			`EX_CMP_GT: begin
				aluNext.tBit	= (regValRs > regValRt);	// Unsigned
			end
			default: begin
				// Unknown sub-op gives zero result, flags clear
			end
		endcase
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			ex1Op.ucmd		<= `EX_UCMD_NOP;
			ex1Op.subOp		<= '0;
			ex1Op.regIdRm	<= `EX_REG_ZZR;
		end else if (!exHold) begin
			if (accept) begin
				ex1Op	<= opIn;
			end else begin
				// Bubble into execute-2
				ex1Op.ucmd		<= `EX_UCMD_NOP;
				ex1Op.subOp		<= '0;
				ex1Op.regIdRm	<= `EX_REG_ZZR;
			end
		end
	end

	// Result follows the op, frozen with it during hold
	always_ff @(posedge clock) begin
		if (accept)
			aluRes <= aluNext;
	end

endmodule

// ==== exMul.sv ====
// Two-stage pipelined 32x32 unsigned multiplier with 64-bit product
`timescale 1ns/1ps
`include "exPipe_consts.svh"

module exMul import exPipePkg::*; (
	input  logic					clock,
	input  logic					rst,
	input  logic					issue,
	input  logic					exHold,		// Freezes stage one only
	input  logic [`EX_VAL_W-1:0]	regValRs,
	input  logic [`EX_VAL_W-1:0]	regValRt,
	output logic [`EX_VAL_W-1:0]	mulProd
);

	exMulOps_t		mulOps;		// Stage one operands
	logic			accept;

	assign accept = issue && !exHold;

	// Stage one
	// Captures low halves when execute-1 takes an op
	always_ff @(posedge clock) begin
		if (rst) begin
			mulOps <= '0;		// Product settles to zero after reset
		end else if (accept) begin
			mulOps.opA <= regValRs[`EX_MUL_W-1:0];
			mulOps.opB <= regValRt[`EX_MUL_W-1:0];
		end
	end

	// Stage two
	// Free running, product ready one cycle after ex1Op shows MUL3
	always_ff @(posedge clock) begin
		mulProd <= mulOps.opA * mulOps.opB;		// 32x32 into 64
	end

endmodule

// ==== exStage2.sv ====
// Execute-2 stage with writeback select, status update, flush and hold counter
`timescale 1ns/1ps
`include "exPipe_consts.svh"

module exStage2 import exPipePkg::*; (
	input  logic					clock,
	input  logic					rst,
	input  exOp_t					ex1Op,			// Op from execute-1
	input  exAluRes_t				aluRes,
	input  logic [`EX_VAL_W-1:0]	mulProd,
	input  logic					opBraFlush,		// Cancel op in this stage
	output exWb_t					wbOut,
	output logic [7:0]				regOutSr,		// Status register
	output logic					exHold
);

	logic [`EX_HOLD_W-1:0]	holdCnt;		// Cycles held so far
	logic [`EX_HOLD_W-1:0]	holdNeed;		// Hold length for this op
	logic [5:0]				opUCmd;			// Command after flush
	logic					opEnable;
	logic					doWb;			// Op writes regIdRm
	logic [`EX_VAL_W-1:0]	wbVal;
	logic					doCarry;		// ALU carry into SR bit 1
	logic					doTBit;			// Compare into SR bit 0

	always_comb begin
		opEnable	= !opBraFlush;
		opUCmd		= opEnable ? ex1Op.ucmd : `EX_UCMD_NOP;

		doWb		= 1'b0;
		wbVal		= aluRes.value;		// Default source
		doCarry		= 1'b0;
		doTBit		= 1'b0;
		holdNeed	= '0;

		case (opUCmd)
			`EX_UCMD_NOP: begin
			end

			`EX_UCMD_ALU3: begin
				doWb	= 1'b1;
				wbVal	= aluRes.value;
				doCarry	= 1'b1;
			end

			`EX_UCMD_ALUCMP: begin
				doTBit	= 1'b1;			// No register write
			end

			`EX_UCMD_MUL3: begin
				doWb		= 1'b1;
				wbVal		= mulProd;
				holdNeed	= `EX_HOLD_MUL;		// Let stage two catch up
			end

			`EX_UCMD_IXT: begin
				case (ex1Op.subOp.sys.sysOp)
					`EX_IXT_SLEEP: holdNeed = `EX_HOLD_SLEEP;
					`EX_IXT_NOP: begin
					end
					default: begin
					end
				endcase
			end

			default: begin
				// Unknown command treated as NOP
			end
		endcase

		exHold = (holdCnt < holdNeed);
	end

	// Write only once the hold is over and the product is ready
	always_comb begin
		wbOut.regId	= (doWb && !exHold) ? ex1Op.regIdRm : `EX_REG_ZZR;
		wbOut.value	= wbVal;
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			holdCnt		<= '0;
			regOutSr	<= '0;
		end else begin
			if (exHold)
				holdCnt <= holdCnt + 1'b1;	// One more cycle held
			else
				holdCnt <= '0;		// Ready for next op

			if (doCarry)
				regOutSr[1] <= aluRes.carry;
			if (doTBit)
				regOutSr[0] <= aluRes.tBit;
		end
	end

endmodule

// ==== exPipeTop.sv ====
// Top level joining the execute-1 ALU, multiplier and execute-2 stage
`timescale 1ns/1ps
`include "exPipe_consts.svh"

module exPipeTop import exPipePkg::*; (
	input  logic					clock,
	input  logic					rst,
	input  logic					issue,
	input  exOp_t					opIn,
	input  logic [`EX_VAL_W-1:0]	regValRs,
	input  logic [`EX_VAL_W-1:0]	regValRt,
	input  logic					opBraFlush,
	output exWb_t					wbOut,
	output logic [7:0]				regOutSr,
	output logic					exHold
);

	exOp_t					ex1Op;		// Execute-1 to execute-2
	exAluRes_t				aluRes;
	logic [`EX_VAL_W-1:0]	mulProd;

	exAlu alu0 (
		.clock		(clock),
		.rst		(rst),
		.issue		(issue),
		.exHold		(exHold),
		.opIn		(opIn),
		.regValRs	(regValRs),
		.regValRt	(regValRt),
		.ex1Op		(ex1Op),
		.aluRes		(aluRes)
	);

	// Sees the same issue as the ALU
	exMul mul0 (
		.clock		(clock),
		.rst		(rst),
		.issue		(issue),
		.exHold		(exHold),
		.regValRs	(regValRs),
		.regValRt	(regValRt),
		.mulProd	(mulProd)
	);

	exStage2 ex2 (
		.clock		(clock),
		.rst		(rst),
		.ex1Op		(ex1Op),
		.aluRes		(aluRes),
		.mulProd	(mulProd),
		.opBraFlush	(opBraFlush),
		.wbOut		(wbOut),
		.regOutSr	(regOutSr),
		.exHold		(exHold)		// Back to execute-1
	);

endmodule

// ==== tbClock.sv ====
// Testbench clock and reset generator
`timescale 1ns/1ps

module tbClock (
	output logic	clock,
	output logic	rst
);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;		// 20 ns period
	end

	initial begin
		rst = 1'b1;
		repeat (4) @(posedge clock);
		@(negedge clock);				// Release away from the active edge
		rst = 1'b0;
	end

endmodule

// ==== exPipe_tb.sv ====
// Testbench with stimulus, reference model, LCG and assertions for exPipeTop
`timescale 1ns/1ps
`include "exPipe_consts.svh"

module exPipe_tb import exPipePkg::*; ();

	logic					clock;
	logic					rst;
	logic					issue;
	exOp_t					opIn;
	logic [`EX_VAL_W-1:0]	regValRs;
	logic [`EX_VAL_W-1:0]	regValRt;
	logic					opBraFlush;
	exWb_t					wbOut;
	logic [7:0]				regOutSr;
	logic					exHold;

	logic [`EX_REGID_W-1:0]	expId;			// Expected wbOut.regId
	logic [`EX_VAL_W-1:0]	expVal;
	logic [7:0]				expSr;
	logic					holdAllowed;	// Hold expected in this stretch
	logic [31:0]			seed = 32'h05069481;
	int						errors = 0;
	int						timeouts = 0;
	int						cnt;

	tbClock clk0 (.clock(clock), .rst(rst));

	exPipeTop dut0 (.clock(clock), .rst(rst), .issue(issue), .opIn(opIn),
		.regValRs(regValRs), .regValRt(regValRt), .opBraFlush(opBraFlush),
		.wbOut(wbOut), .regOutSr(regOutSr), .exHold(exHold));

	function automatic logic [31:0] lcgNext();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	function automatic logic [63:0] rand64();
		return {lcgNext(), lcgNext()};
	endfunction

	// Random destination, sub-op placed in the view that ucmd reads
	function automatic exOp_t makeOp(input logic [5:0] ucmd, input logic [3:0] sub);
		exOp_t			op;
		logic [31:0]	r;
		r = lcgNext();
		op.ucmd = ucmd;
		op.regIdRm = r[`EX_REGID_W-1:0];
		if (ucmd == `EX_UCMD_IXT) begin
			op.subOp.sys.spare = 2'b00;
			op.subOp.sys.sysOp = sub;
		end else begin
			op.subOp.alu.spare = 2'b00;
			op.subOp.alu.aluOp = sub;
		end
		return op;
	endfunction

	// Checked every cycle once out of reset, idle expects ZZR
	wbIdChk: assert property (@(posedge clock) disable iff (rst) wbOut.regId == expId)
		else begin
			errors++;
			$display("[ERROR] wbOut.regId exp %h got %h", expId, $sampled(wbOut.regId));
		end
	wbValChk: assert property (@(posedge clock) disable iff (rst)
			(expId == `EX_REG_ZZR) || (wbOut.value == expVal))
		else begin
			errors++;
			$display("[ERROR] wbOut.value exp %h got %h", expVal, $sampled(wbOut.value));
		end
	srChk: assert property (@(posedge clock) disable iff (rst) regOutSr == expSr)
		else begin
			errors++;
			$display("[ERROR] regOutSr exp %h got %h", expSr, $sampled(regOutSr));
		end
	holdChk: assert property (@(posedge clock) disable iff (rst) holdAllowed || !exHold)
		else begin
			errors++;
			$display("[ERROR] exHold exp %h got %h", 1'b0, $sampled(exHold));
		end

	// Issue one op at a falling edge, model it, follow it through execute-2
	task automatic runOp(input exOp_t op, input logic [63:0] rs, input logic [63:0] rt,
			input logic flush);
		logic [64:0]	sum;
		logic [63:0]	val;
		logic			carry;
		logic			tBit;
		logic [5:0]		cmd;
		int				holdExp;
		int				n;
		sum = '0;
		val = '0;
		carry = 1'b0;
		tBit = 1'b0;
		holdExp = 0;
		cmd = flush ? `EX_UCMD_NOP : op.ucmd;		// Flushed op acts as NOP
		case (op.subOp.alu.aluOp)
			`EX_ALU_ADD: begin
				sum = {1'b0, rs} + {1'b0, rt};
				val = sum[63:0];
				carry = sum[64];
			end
			`EX_ALU_SUB: begin
				val = rs - rt;
				carry = (rs < rt);		// Borrow
			end
			`EX_ALU_AND: val = rs & rt;
			`EX_ALU_OR:  val = rs | rt;
			`EX_ALU_XOR: val = rs ^ rt;
			`EX_CMP_EQ:  tBit = (rs == rt);
			`EX_CMP_GT:  tBit = (rs > rt);
			default: val = '0;
		endcase
		if (cmd == `EX_UCMD_MUL3)
			holdExp = `EX_HOLD_MUL;
		else if (cmd == `EX_UCMD_IXT && op.subOp.sys.sysOp == `EX_IXT_SLEEP)
			holdExp = `EX_HOLD_SLEEP;
		opIn = op;
		regValRs = rs;
		regValRt = rt;
		issue = 1'b1;
		@(posedge clock);				// Accepted here
		@(negedge clock);
		opBraFlush = flush;				// Op now in execute-2
		if (holdExp > 0) begin
			holdAllowed = 1'b1;
			n = 0;
			while (exHold && n < 20) begin		// Inputs kept during the hold
				@(posedge clock);
				@(negedge clock);
				n++;
			end
			if (exHold) begin
				timeouts++;
				$display("Timeout: exHold still high after %0d cycles", n);
			end
			holdLen: assert (n == holdExp)
				else begin
					errors++;
					$display("[ERROR] exHold cycles exp %h got %h", holdExp, n);
				end
			holdAllowed = 1'b0;
		end
		issue = 1'b0;
		if (cmd == `EX_UCMD_ALU3) begin
			expId = op.regIdRm;
			expVal = val;
		end else if (cmd == `EX_UCMD_MUL3) begin
			expId = op.regIdRm;
			expVal = {32'b0, rs[31:0]} * {32'b0, rt[31:0]};
		end
		@(posedge clock);				// wbOut checked, status written
		@(negedge clock);
		expId = `EX_REG_ZZR;			// Next edge loads a bubble
		opBraFlush = 1'b0;
		if (cmd == `EX_UCMD_ALU3)
			expSr[1] = carry;
		if (cmd == `EX_UCMD_ALUCMP)
			expSr[0] = tBit;
	endtask

	initial begin
		logic [63:0] a;
		issue = 1'b0;
		opIn = '0;
		regValRs = '0;
		regValRt = '0;
		opBraFlush = 1'b0;
		expId = `EX_REG_ZZR;
		expVal = '0;
		expSr = '0;
		holdAllowed = 1'b0;
		cnt = 0;
		while (rst !== 1'b0 && cnt < 20) begin
			@(negedge clock);
			cnt++;
		end
		if (rst !== 1'b0) begin
			timeouts++;
			$display("Timeout: reset never released");
		end
		repeat (2) @(negedge clock);		// Idle state after reset
		for (int i = 0; i < 20; i++)
			runOp(makeOp(`EX_UCMD_ALU3, 4'(i % 5)), rand64(), rand64(), 1'b0);
		for (int i = 0; i < 10; i++) begin
			a = rand64();
			runOp(makeOp(`EX_UCMD_ALUCMP, (i % 2) ? `EX_CMP_GT : `EX_CMP_EQ), a,
				(i % 4 == 0) ? a : rand64(), 1'b0);		// Some equal pairs
		end
		for (int i = 0; i < 3; i++)
			runOp(makeOp(`EX_UCMD_MUL3, 4'h0), rand64(), rand64(), 1'b0);
		runOp(makeOp(`EX_UCMD_IXT, `EX_IXT_SLEEP), rand64(), rand64(), 1'b0);
		runOp(makeOp(`EX_UCMD_ALU3, `EX_ALU_ADD), '1, '1, 1'b1);		// Carry would set
		runOp(makeOp(`EX_UCMD_IXT, `EX_IXT_SLEEP), rand64(), rand64(), 1'b1);
		repeat (3) @(negedge clock);
		$display("Errors: %0d  Timeouts: %0d", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

// ==== project.f ====
+incdir+.
exPipePkg.sv
exAlu.sv
exMul.sv
exStage2.sv
exPipeTop.sv
tbClock.sv
exPipe_tb.sv
